// ==== Bender.yml ====
package:
  name: stream_proc

sources:
  - files:
      - common/stream_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/stream_alu.sv
      - verilog/stream_proc_top.sv
  - target: test
    files:
      - testbench/tb_stream_proc.sv

// ==== common/stream_pkg.sv ====
package stream_pkg;

  // word widths of the data path.
  localparam int data_w = 32;
  localparam int opnd_w = 16;

  // both FIFOs hold 8 words.
  localparam int fifo_addr_w = 3;

  typedef enum logic [1:0] {
    op_pass = 2'd0,
    op_add  = 2'd1,
    op_xor  = 2'd2,
    op_acc  = 2'd3
  } op_e;

  // a command as it enters the input stream.
  typedef struct packed {
    op_e               op;
    logic [opnd_w-1:0] operand;
    logic [data_w-1:0] data;
  } cmd_t;

  // the op field is echoed from the command that produced the result.
  typedef struct packed {
    op_e               op;
    logic [data_w-1:0] data;
  } rsp_t;

  localparam int cmd_w = $bits(cmd_t);
  localparam int rsp_w = $bits(rsp_t);

endpackage

// ==== src.f ====
common/stream_pkg.sv
verilog/stream_fifo.sv
verilog/stream_alu.sv
verilog/stream_proc_top.sv
testbench/tb_stream_proc.sv

// ==== testbench/stream_tests.txt ====
# cmd op operand data expected, all numbers in hex; the operand is unused by pass and acc.
# clear takes no fields; fill gives the first data word of 17 pass commands.
cmd pass 0000 12345678 12345678
cmd pass ffff deadbeef deadbeef
cmd add 0001 00000001 00000002
cmd add ffff ffffffff 0000fffe
cmd add 1234 a0000000 a0001234
cmd xor ffff 0000ffff 00000000
cmd xor a5a5 12345678 1234f3dd
cmd xor 0f0f ffffffff fffff0f0
cmd acc 0000 00000010 00000010
cmd acc 9999 00000020 00000030
cmd pass 0000 00000005 00000005
cmd acc 0000 fffffff0 00000020
cmd add 8000 7fff8000 80000000
cmd acc 0000 00000001 00000021
clear
cmd acc 0000 00000007 00000007
cmd acc 0000 00000003 0000000a
cmd xor 00ff 000000ff 00000000
fill 00001000
cmd acc 0000 00000006 00000010
cmd add 0010 00000000 00000010
cmd add 0000 cafef00d cafef00d
cmd xor 0000 cafef00d cafef00d
cmd pass 1111 00000000 00000000
clear
cmd acc 0000 00000100 00000100
cmd acc 0000 00000200 00000300
cmd add ffff 00010001 00020000
cmd xor 8001 80018001 80010000
fill 0000a000
cmd acc 0000 00000001 00000301

// ==== testbench/tb_stream_proc.sv ====
`timescale 1ns/100ps

module tb_stream_proc;

  logic                             clk;
  logic                             rst;
  logic                             clear;
  logic                             in_valid;
  stream_pkg::cmd_t                 in_cmd;
  logic                             in_ready;
  logic                             out_valid;
  stream_pkg::rsp_t                 out_rsp;
  logic                             out_ready;
  logic [stream_pkg::fifo_addr_w:0] in_level;
  logic [stream_pkg::fifo_addr_w:0] out_level;

  // results still owed by the DUT, oldest first.
  stream_pkg::rsp_t exp_q[$];
  integer           seed;
  logic             hold_ready;
  logic             hold_now;
  logic             prev_stall;
  stream_pkg::rsp_t prev_rsp;

  stream_proc_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .in_valid  (in_valid),
    .in_cmd    (in_cmd),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rsp   (out_rsp),
    .out_ready (out_ready),
    .in_level  (in_level),
    .out_level (out_level)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic parse_op(input string name, output stream_pkg::op_e op);
    case (name)
      "pass": op = stream_pkg::op_pass;
      "add": op = stream_pkg::op_add;
      "xor": op = stream_pkg::op_xor;
      "acc": op = stream_pkg::op_acc;
      default: abort_run($sformatf("unknown opcode %s in the data file", name));
    endcase
  endtask

  // called one step after a rising edge and returns at the same point.
  task automatic send_cmd(input stream_pkg::cmd_t c, input stream_pkg::rsp_t r);
    int n;
    n = 0;
    exp_q.push_back(r);
    in_valid = 1'b1;
    in_cmd   = c;
    @(negedge clk);
    while (!in_ready) begin
      n++;
      if (n > 100) begin
        abort_run("in_ready stayed low too long while a command was offered");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      n++;
      if (n > 500) begin
        abort_run("expected results never came out of the DUT");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // ten stalled words leave one in the input FIFO, one in the ALU register
  // and eight in the output FIFO, and clear has to drop all of them.
  task automatic pulse_clear();
    stream_pkg::cmd_t c;
    stream_pkg::rsp_t r;
    wait_drain();
    hold_ready = 1'b1;
    for (int i = 0; i < 10; i++) begin
      c.op      = stream_pkg::op_acc;
      c.operand = '0;
      c.data    = 32'h100 + i;
      r.op      = stream_pkg::op_acc;
      r.data    = '0;
      send_cmd(c, r);
    end
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear = 1'b0;
    exp_q.delete();
    @(negedge clk);
    check_val("out_valid", out_valid, 1'b0);
    check_val("in_level", in_level, 0);
    check_val("out_level", out_level, 0);
    @(posedge clk);
    #1;
    hold_ready = 1'b0;
  endtask

  // 17 words fill the input FIFO, the ALU register and the output FIFO.
  task automatic run_fill(input logic [stream_pkg::data_w-1:0] base);
    stream_pkg::cmd_t c;
    stream_pkg::rsp_t r;
    int               n;
    wait_drain();
    hold_ready = 1'b1;
    for (int i = 0; i < 17; i++) begin
      c.op      = stream_pkg::op_pass;
      c.operand = '0;
      c.data    = base + i;
      r.op      = stream_pkg::op_pass;
      r.data    = base + i;
      send_cmd(c, r);
    end
    n = 0;
    @(negedge clk);
    while (in_level != 8 || out_level != 8) begin
      n++;
      if (n > 100) begin
        abort_run("the FIFOs did not fill up while out_ready was held low");
      end
      @(negedge clk);
    end
    check_val("in_ready", in_ready, 1'b0);
    @(posedge clk);
    #1;
    hold_ready = 1'b0;
    wait_drain();
  endtask

  always @(posedge clk) begin
    hold_now = hold_ready;
    #1;
    if (hold_now) begin
      out_ready = 1'b0;
    end else begin
      out_ready = ($random(seed) & 32'h3) != 0;
    end
  end

  // outputs are sampled at the falling edge, half a cycle away from any change.
  always @(negedge clk) begin
    if (!rst) begin
      if (prev_stall) begin
        check_val("out_valid", out_valid, 1'b1);
        check_val("out_rsp", out_rsp, prev_rsp);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a result came out with no command left to match it");
        end else begin
          check_val("out_rsp.op", out_rsp.op, exp_q[0].op);
          check_val("out_rsp.data", out_rsp.data, exp_q[0].data);
          void'(exp_q.pop_front());
        end
      end
      // a stalled result may be dropped by a clear at the next edge.
      prev_stall = out_valid && !out_ready && !clear;
      prev_rsp   = out_rsp;
    end
  end

  initial begin : main
    int                            fd;
    int                            code;
    logic                          done;
    string                         kind;
    string                         opname;
    string                         rest;
    logic [stream_pkg::opnd_w-1:0] operand;
    logic [stream_pkg::data_w-1:0] data;
    logic [stream_pkg::data_w-1:0] expd;
    stream_pkg::cmd_t              c;
    stream_pkg::rsp_t              r;
    clk        = 1'b0;
    rst        = 1'b1;
    clear      = 1'b0;
    in_valid   = 1'b0;
    in_cmd     = '0;
    out_ready  = 1'b0;
    hold_ready = 1'b1;
    prev_stall = 1'b0;
    prev_rsp   = '0;
    seed       = 32'ha9dd02c6;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_val("out_valid", out_valid, 1'b0);
    check_val("in_ready", in_ready, 1'b1);
    check_val("in_level", in_level, 0);
    check_val("out_level", out_level, 0);
    @(posedge clk);
    #1;
    hold_ready = 1'b0;
    fd = $fopen("testbench/stream_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/stream_tests.txt");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else if (kind == "cmd") begin
        code = $fscanf(fd, "%s %h %h %h", opname, operand, data, expd);
        if (code != 4) begin
          abort_run("a cmd line in the data file is incomplete");
        end
        parse_op(opname, c.op);
        c.operand = operand;
        c.data    = data;
        r.op      = c.op;
        r.data    = expd;
        send_cmd(c, r);
      end else if (kind == "clear") begin
        pulse_clear();
      end else if (kind == "fill") begin
        code = $fscanf(fd, "%h", data);
        if (code != 1) begin
          abort_run("a fill line in the data file has no start word");
        end
        run_fill(data);
      end else begin
        abort_run($sformatf("unknown line kind %s in the data file", kind));
      end
    end
    $fclose(fd);
    wait_drain();
    @(negedge clk);
    check_val("out_valid", out_valid, 1'b0);
    check_val("in_level", in_level, 0);
    check_val("out_level", out_level, 0);
    if (exp_q.size() != 0) begin
      abort_run("results were still owed at the end of the run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== verilog/stream_alu.sv ====
`timescale 1ns/100ps

module stream_alu (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,

  input  logic             in_valid,
  input  stream_pkg::cmd_t in_cmd,
  output logic             in_ready,

  output logic             out_valid,
  output stream_pkg::rsp_t out_rsp,
  input  logic             out_ready
);

  logic [stream_pkg::data_w-1:0] operand_ext;
  logic [stream_pkg::data_w-1:0] acc_q;
  logic [stream_pkg::data_w-1:0] acc_sum;
  logic [stream_pkg::data_w-1:0] result;
  logic                          take;
  logic                          valid_q;
  stream_pkg::rsp_t              rsp_q;

  // the operand is unsigned.
  assign operand_ext = {
    {(stream_pkg::data_w - stream_pkg::opnd_w){1'b0}},
    in_cmd.operand
  };

  assign acc_sum = acc_q + in_cmd.data;

  always_comb begin
    case (in_cmd.op)
      stream_pkg::op_pass: begin
        result = in_cmd.data;
      end
      stream_pkg::op_add: begin
        result = in_cmd.data + operand_ext;
      end
      stream_pkg::op_xor: begin
        result = in_cmd.data ^ operand_ext;
      end
      stream_pkg::op_acc: begin
        result = acc_sum;
      end
      default: begin
        result = in_cmd.data;
      end
    endcase
  end

  // one result register, which can be refilled in the cycle it drains.
  assign in_ready = ~valid_q | out_ready;
  assign take     = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      valid_q <= 1'b0;
      acc_q   <= '0;
    end else begin
      if (take) begin
        valid_q <= 1'b1;
      end else if (out_ready) begin
        valid_q <= 1'b0;
      end
      if (take && in_cmd.op == stream_pkg::op_acc) begin
        acc_q <= acc_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp_q.op   <= in_cmd.op;
      rsp_q.data <= result;
    end
  end

  assign out_valid = valid_q;
  assign out_rsp   = rsp_q;

  a_hold_stalled: assert property (
    @(posedge clk) disable iff (rst || clear)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_rsp))
  ) else $error("alu result changed while stalled");

endmodule

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo #(
  parameter int addr_w = stream_pkg::fifo_addr_w,
  parameter int width  = stream_pkg::data_w
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,

  input  logic             din_valid,
  input  logic [width-1:0] din,
  output logic             din_ready,

  output logic             dout_valid,
  output logic [width-1:0] dout,
  input  logic             dout_ready,

  output logic [addr_w:0]  count,
  output logic             full,
  output logic             empty
);

  localparam int depth = 1 << addr_w;

  logic [width-1:0]  mem [depth];
  logic [addr_w-1:0] wptr_q;
  logic [addr_w-1:0] rptr_q;
  logic [addr_w-1:0] wptr_inc;
  logic [addr_w-1:0] rptr_inc;
  logic [addr_w:0]   count_q;
  logic              full_q;
  logic              empty_q;
  logic              live_q;
  logic              enq;
  logic              deq;

  assign enq = din_valid & din_ready;
  assign deq = dout_valid & dout_ready;

  assign wptr_inc = wptr_q + addr_w'(1);
  assign rptr_inc = rptr_q + addr_w'(1);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (enq) begin
        wptr_q <= wptr_inc;
      end
      if (deq) begin
        rptr_q <= rptr_inc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enq) begin
      mem[wptr_q] <= din;
    end
  end

  assign dout = mem[rptr_q];

  // the flags only move when the fill level changes, so a simultaneous
  // enqueue and dequeue leaves them alone.
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else if (enq ^ deq) begin
      full_q  <= enq && (wptr_inc == rptr_q);
      empty_q <= deq && (rptr_inc == wptr_q);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count_q <= '0;
    end else if (enq && !deq) begin
      count_q <= count_q + (addr_w+1)'(1);
    end else if (!enq && deq) begin
      count_q <= count_q - (addr_w+1)'(1);
    end
  end

  // keeps the write side closed while reset is held.
  always_ff @(posedge clk) begin
    if (rst) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign din_ready  = live_q & ~full_q;
  assign dout_valid = ~empty_q;

  assign count = count_q;
  assign full  = full_q;
  assign empty = empty_q;

  a_count_range: assert property (
    @(posedge clk) disable iff (rst)
    count_q <= (addr_w+1)'(depth)
  ) else $error("fifo count above depth");

  // the empty flag and the count are kept apart, so they are checked
  // against each other here.
  a_no_deq_empty: assert property (
    @(posedge clk) disable iff (rst)
    deq |-> count_q != '0
  ) else $error("fifo dequeue while empty");

endmodule

// ==== verilog/stream_proc_top.sv ====
`timescale 1ns/100ps

module stream_proc_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             clear,

  input  logic                             in_valid,
  input  stream_pkg::cmd_t                 in_cmd,
  output logic                             in_ready,

  output logic                             out_valid,
  output stream_pkg::rsp_t                 out_rsp,
  input  logic                             out_ready,

  output logic [stream_pkg::fifo_addr_w:0] in_level,
  output logic [stream_pkg::fifo_addr_w:0] out_level
);

  logic             cmd_valid;
  logic             cmd_ready;
  stream_pkg::cmd_t cmd;

  logic             rsp_valid;
  logic             rsp_ready;
  stream_pkg::rsp_t rsp;

  stream_fifo #(
    .addr_w (stream_pkg::fifo_addr_w),
    .width  (stream_pkg::cmd_w)
  ) u_in_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .din_valid  (in_valid),
    .din        (in_cmd),
    .din_ready  (in_ready),
    .dout_valid (cmd_valid),
    .dout       (cmd),
    .dout_ready (cmd_ready),
    .count      (in_level),
    .full       (),
    .empty      ()
  );

  stream_alu u_alu (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .in_valid  (cmd_valid),
    .in_cmd    (cmd),
    .in_ready  (cmd_ready),
    .out_valid (rsp_valid),
    .out_rsp   (rsp),
    .out_ready (rsp_ready)
  );

  // results wait here while the consumer stalls.
  stream_fifo #(
    .addr_w (stream_pkg::fifo_addr_w),
    .width  (stream_pkg::rsp_w)
  ) u_out_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .din_valid  (rsp_valid),
    .din        (rsp),
    .din_ready  (rsp_ready),
    .dout_valid (out_valid),
    .dout       (out_rsp),
    .dout_ready (out_ready),
    .count      (out_level),
    .full       (),
    .empty      ()
  );

endmodule
